// File: source/l2i_pkg.sv
package l2i_pkg;

    // geometry
    localparam int TAG_W    = 24;
    localparam int INDEX_W  = 4;
    localparam int ADDR_W   = TAG_W + INDEX_W;
    localparam int NUM_SETS = 1 << INDEX_W;
    localparam int LINE_W   = 128;

    // one replacement bit per set only covers two ways
    localparam int NUM_WAYS = 2;

    typedef logic [ADDR_W-1:0]  line_addr_t;
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [LINE_W-1:0]  line_t;
    typedef logic               way_t;

    // result of the tag compare for the current request
    typedef struct packed {
        logic hit;
        way_t hit_way;
        way_t victim_way;
    } lookup_t;

    typedef enum logic [0:0] {
        COMPARE_TAG = 1'b0,
        ALLOCATE    = 1'b1
    } l2i_state_e;

    // upper bits of a line address
    function automatic tag_t addr_tag(input line_addr_t addr);
        return addr[ADDR_W-1:INDEX_W];
    endfunction

    // lower bits select the set
    function automatic index_t addr_index(input line_addr_t addr);
        return addr[INDEX_W-1:0];
    endfunction

endpackage

// File: source/l2i_tag_array.sv
`timescale 1ns/1ps

module l2i_tag_array
    import l2i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  line_addr_t cache_addr,
    input  logic       fill_en,
    input  logic       touch_en,
    output lookup_t    lookup
);

    // tag storage, guarded by the valid bits
    tag_t                tag_mem [NUM_SETS][NUM_WAYS];

    logic [NUM_WAYS-1:0] valid_q [NUM_SETS];

    // way to evict next in each set
    way_t                repl_q  [NUM_SETS];

    tag_t                req_tag;
    index_t              req_index;
    logic [NUM_WAYS-1:0] way_match;

    assign req_tag   = addr_tag(cache_addr);
    assign req_index = addr_index(cache_addr);

    // compare against every way of the set
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_match[w] = valid_q[req_index][w] &&
                           (tag_mem[req_index][w] == req_tag);
        end
    end

    // two ways, so way 1 matching means hit way 1
    always_comb begin
        lookup.hit        = |way_match;
        lookup.hit_way    = way_t'(way_match[1]);
        lookup.victim_way = repl_q[req_index];
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[req_index][lookup.victim_way] <= req_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                valid_q[s] <= '0;
                repl_q[s]  <= '0;
            end
        end else if (fill_en) begin
            valid_q[req_index][lookup.victim_way] <= 1'b1;
            // freshly filled way becomes most recent
            repl_q[req_index] <= ~lookup.victim_way;
        end else if (touch_en) begin
            repl_q[req_index] <= ~lookup.hit_way;
        end
    end

endmodule

// File: source/l2i_data_array.sv
`timescale 1ns/1ps

module l2i_data_array
    import l2i_pkg::*;
(
    input  logic       clk,
    input  line_addr_t cache_addr,
    input  lookup_t    lookup,
    input  logic       fill_en,
    input  line_t      mem_rdata,
    output line_t      cache_rdata
);

    // line storage, contents only meaningful where valid is set
    line_t  data_mem [NUM_SETS][NUM_WAYS];

    index_t req_index;

    assign req_index = addr_index(cache_addr);

    // fill lands in the victim way of the requested set
    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[req_index][lookup.victim_way] <= mem_rdata;
        end
    end

    // hit way line, taken by the requester only with l2_ready
    assign cache_rdata = data_mem[req_index][lookup.hit_way];

endmodule

// File: source/l2i_ctrl.sv
`timescale 1ns/1ps

module l2i_ctrl
    import l2i_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cache_read,
    input  lookup_t lookup,
    input  logic    mem_ready,
    output logic    l2_ready,
    output logic    mem_read,
    output logic    fill_en,
    output logic    touch_en
);

    l2i_state_e state_q;
    l2i_state_e state_d;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= COMPARE_TAG;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d  = state_q;
        l2_ready = 1'b0;
        mem_read = 1'b0;
        fill_en  = 1'b0;
        touch_en = 1'b0;

        case (state_q)
            COMPARE_TAG: begin
                if (cache_read) begin
                    if (lookup.hit) begin
                        // answer in the request cycle
                        l2_ready = 1'b1;
                        touch_en = 1'b1;
                    end else begin
                        mem_read = 1'b1;
                        state_d  = ALLOCATE;
                    end
                end
            end

            ALLOCATE: begin
                // held until the memory answers
                mem_read = 1'b1;
                if (mem_ready) begin
                    fill_en = 1'b1;
                    state_d = COMPARE_TAG;
                end
            end

            default: begin
                state_d = COMPARE_TAG;
            end
        endcase
    end

endmodule

// File: source/l2i_cache.sv
`timescale 1ns/1ps

module l2i_cache
    import l2i_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,

    // requester side
    input  logic       cache_read,
    input  line_addr_t cache_addr,
    output line_t      cache_rdata,
    output logic       l2_ready,

    // memory side
    output logic       mem_read,
    output line_addr_t mem_addr,
    input  line_t      mem_rdata,
    input  logic       mem_ready
);

    lookup_t lookup;
    logic    fill_en;
    logic    touch_en;

    // request address stays stable for the whole miss
    assign mem_addr = cache_addr;

    l2i_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_read (cache_read),
        .lookup     (lookup),
        .mem_ready  (mem_ready),
        .l2_ready   (l2_ready),
        .mem_read   (mem_read),
        .fill_en    (fill_en),
        .touch_en   (touch_en)
    );

    l2i_tag_array u_tag_array (
        .clk        (clk),
        .rst_n      (rst_n),
        .cache_addr (cache_addr),
        .fill_en    (fill_en),
        .touch_en   (touch_en),
        .lookup     (lookup)
    );

    l2i_data_array u_data_array (
        .clk         (clk),
        .cache_addr  (cache_addr),
        .lookup      (lookup),
        .fill_en     (fill_en),
        .mem_rdata   (mem_rdata),
        .cache_rdata (cache_rdata)
    );

endmodule

// File: tb/l2i_cache_checker.sv
`timescale 1ns/1ps

module l2i_cache_checker (
    input logic clk,
    input logic rst_n,
    input logic cache_read,
    input logic l2_ready,
    input logic mem_read,
    input logic mem_ready
);

    // miss request stays up until the memory answers
    property mem_read_held;
        @(posedge clk) disable iff (!rst_n)
            mem_read && !mem_ready |=> mem_read;
    endproperty

    property ready_needs_read;
        @(posedge clk) disable iff (!rst_n)
            l2_ready |-> cache_read;
    endproperty

    property ready_excludes_mem_read;
        @(posedge clk) disable iff (!rst_n)
            !(l2_ready && mem_read);
    endproperty

    property ready_low_after_reset;
        @(posedge clk) !rst_n |=> !l2_ready;
    endproperty

    held_a: assert property (mem_read_held)
        else $error("mem_read dropped before mem_ready");
    with_read_a: assert property (ready_needs_read)
        else $error("l2_ready without cache_read");
    exclusive_a: assert property (ready_excludes_mem_read)
        else $error("l2_ready and mem_read high together");
    reset_a: assert property (ready_low_after_reset)
        else $error("l2_ready high right after reset");

endmodule

bind l2i_cache l2i_cache_checker u_checker (
    .clk        (clk),
    .rst_n      (rst_n),
    .cache_read (cache_read),
    .l2_ready   (l2_ready),
    .mem_read   (mem_read),
    .mem_ready  (mem_ready)
);

// File: tb/l2i_cache_tb.sv
`timescale 1ns/1ps

module l2i_cache_tb
    import l2i_pkg::*;
();

    localparam int          CLK_PERIOD    = 8;
    localparam int          RESET_CYCLES  = 5;
    localparam int          READY_TIMEOUT = 50;
    localparam int          CASE_WORDS    = 3 * 64;
    localparam logic [31:0] OP_READ       = 32'h1;
    localparam logic [31:0] OP_RESET      = 32'h2;
    localparam logic [31:0] OP_END        = 32'hf;

    logic       clk;
    logic       rst_n;
    logic       cache_read;
    line_addr_t cache_addr;
    line_t      cache_rdata;
    logic       l2_ready;
    logic       mem_read;
    line_addr_t mem_addr;
    line_t      mem_rdata;
    logic       mem_ready;

    // three words per case for op, line address and expected hit flag
    logic [31:0] case_mem [0:CASE_WORDS-1];

    integer seed;
    int     errors;
    int     passed;
    int     failed;

    l2i_cache UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .cache_read  (cache_read),
        .cache_addr  (cache_addr),
        .cache_rdata (cache_rdata),
        .l2_ready    (l2_ready),
        .mem_read    (mem_read),
        .mem_addr    (mem_addr),
        .mem_rdata   (mem_rdata),
        .mem_ready   (mem_ready)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // address word xor a5a5a5a5 repeated four times
    function automatic line_t expected_line(input line_addr_t addr);
        logic [31:0] word;
        word = {4'h0, addr} ^ 32'ha5a5a5a5;
        return {4{word}};
    endfunction

    task automatic check_value(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    // memory model answers a miss after 1 to 4 cycles
    initial begin : memory_model
        int         delay;
        line_addr_t req_addr;
        mem_ready = 1'b0;
        mem_rdata = '0;
        forever begin
            @(negedge clk);
            if (rst_n && mem_read && !mem_ready) begin
                req_addr = mem_addr;
                delay = 1 + ($random(seed) & 3);
                repeat (delay) @(posedge clk);
                #1;
                mem_ready = 1'b1;
                mem_rdata = expected_line(req_addr);
                @(posedge clk);
                #1;
                mem_ready = 1'b0;
                mem_rdata = '0;
            end
        end
    end

    task automatic apply_reset(input int num);
        int errors_before;
        errors_before = errors;
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        cache_read = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_value("l2_ready", line_t'(l2_ready), '0);
        check_value("mem_read", line_t'(mem_read), '0);
        if (errors == errors_before) begin
            passed++;
        end else begin
            failed++;
        end
        $display("case %0d: reset, %s", num, (errors == errors_before) ? "ok" : "failed");
    endtask

    task automatic run_request(input int num, input line_addr_t addr, input logic exp_hit);
        int    waited;
        int    ready_wait;
        int    errors_before;
        logic  seen_mem;
        logic  got_ready;
        line_t rdata;
        errors_before = errors;
        waited = 0;
        ready_wait = -1;
        seen_mem = 1'b0;
        got_ready = 1'b0;
        rdata = '0;
        @(posedge clk);
        #1;
        cache_read = 1'b1;
        cache_addr = addr;
        while (!got_ready && waited < READY_TIMEOUT) begin
            @(negedge clk);
            if (mem_read) begin
                seen_mem = 1'b1;
                check_value("mem_addr", line_t'(mem_addr), line_t'(addr));
            end
            if (mem_ready) begin
                ready_wait = waited;
            end
            if (l2_ready && mem_read) begin
                $display("error at %0t ns: l2_ready and mem_read are high together", $time);
                errors++;
            end
            if (l2_ready) begin
                got_ready = 1'b1;
                rdata = cache_rdata;
            end else begin
                waited++;
            end
        end
        @(posedge clk);
        #1;
        cache_read = 1'b0;
        if (!got_ready) begin
            $display("timeout: read of line %h got no l2_ready within %0d cycles",
                     addr, READY_TIMEOUT);
            errors++;
        end else begin
            check_value("hit", line_t'(!seen_mem), line_t'(exp_hit));
            // a hit answers in the request cycle
            if (exp_hit) begin
                check_value("hit wait cycles", line_t'(waited), '0);
            end
            // a miss answers one cycle after mem_ready
            if (seen_mem) begin
                check_value("cycles after mem_ready", line_t'(waited - ready_wait),
                            line_t'(1));
            end
            check_value("cache_rdata", rdata, expected_line(addr));
        end
        if (errors == errors_before) begin
            passed++;
        end else begin
            failed++;
        end
        $display("case %0d: read %h, %s, %0d wait cycles, %s", num, addr,
                 seen_mem ? "miss" : "hit", waited,
                 (errors == errors_before) ? "ok" : "failed");
    endtask

    initial begin : main
        int          pos;
        int          num;
        logic [31:0] op;
        seed = 68669;
        errors = 0;
        passed = 0;
        failed = 0;
        rst_n = 1'b0;
        cache_read = 1'b0;
        cache_addr = '0;
        for (int i = 0; i < CASE_WORDS; i++) begin
            case_mem[i] = OP_END;
        end
        $readmemh("tb/l2i_cases.txt", case_mem);
        apply_reset(0);
        pos = 0;
        num = 1;
        while (pos + 2 < CASE_WORDS && case_mem[pos] != OP_END) begin
            op = case_mem[pos];
            if (op == OP_READ) begin
                run_request(num, line_addr_t'(case_mem[pos+1]), case_mem[pos+2][0]);
            end else if (op == OP_RESET) begin
                apply_reset(num);
            end else begin
                $display("case %0d: unknown operation %h in the case file", num, op);
                errors++;
                failed++;
            end
            pos += 3;
            num++;
        end
        if (num == 1) begin
            $display("no cases were read from the case file");
            errors++;
        end
        $display("%0d cases passed, %0d failed, %0d errors", passed, failed, errors);
        if (errors == 0 && failed == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tb/l2i_cases.txt
// columns: op, line address, expected hit (1 = hit, 0 = miss)
// op 1 = request, 2 = reset, f = end of cases
// cold miss, then the same line hits
1 0000013 0
1 0000013 1
// second tag in set 3, both stay resident
1 0000023 0
1 0000013 1
1 0000023 1
// a most recent, so c evicts b
1 0000013 1
1 0000033 0
1 0000013 1
1 0000023 0
// set 9 fills leave set 3 alone
1 0000019 0
1 0000029 0
1 0000013 1
1 0000023 1
1 0000019 1
// reset clears all lines
2 0000000 0
1 0000013 0
1 0000013 1
1 0000023 0
// top tag in set 0
1 ffffff0 0
1 ffffff0 1
1 0000013 1
f 0000000 0

// File: list.f
source/l2i_pkg.sv
source/l2i_tag_array.sv
source/l2i_data_array.sv
source/l2i_ctrl.sv
source/l2i_cache.sv
tb/l2i_cache_checker.sv
tb/l2i_cache_tb.sv

// File: Makefile
TOOL     := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := l2i_cache_tb
FILELIST := list.f
LOG      := sim.log
PASS_MSG := === PASS ===

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
